// ==== list.f ====
+incdir+source
source/fix_pkg.sv
source/frame_pkg.sv
source/pixel_calculator.sv
source/scan_generator.sv
source/escape_controller.sv
source/mandel_top.sv
verification/mandel_assert.sv
verification/tb_mandel_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# build with Verilator, run, then look for the pass line in the log

rm -rf obj_dir sim.log build.log

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/10ps \
	--top-module tb_mandel_top -f list.f > build.log 2>&1 &&
	./obj_dir/Vtb_mandel_top +verilator+error+limit+1000 > sim.log 2>&1 ||
	echo "build or simulation returned an error, see build.log and sim.log"

grep -qs "^all tests passed$" sim.log && echo "PASS" && exit 0 ||
	{ echo "FAIL"; exit 1; }

// ==== source/escape_controller.sv ====
`timescale 1ns/10ps
`include "mandel_defs.svh"

module escape_controller import fix_pkg::*, frame_pkg::*;
(
	input logic tb_clk,
	input logic rst_n,
	input logic c_valid,
	input fixed_t c_real,
	input fixed_t c_imag,
	input coord_x_t x,
	input coord_y_t y,
	input fixed_t z_real_out,
	input fixed_t z_imag_out,
	input fixed_t size_squared_out,
	input iter_t pixel,
	output fixed_t z_real_in,
	output fixed_t z_imag_in,
	output fixed_t c_real_in,
	output fixed_t c_imag_in,
	output iter_t iteration_in,
	output logic pixel_next,
	output logic pixel_valid,
	output coord_x_t pixel_x,
	output coord_y_t pixel_y,
	output iter_t pixel_count
);

	localparam logic [1:0] ST_IDLE = 2'd0;
	localparam logic [1:0] ST_LOAD = 2'd1;
	localparam logic [1:0] ST_ITER = 2'd2;

	// threshold split into the two fields of the word
	localparam int ESC_INT = `MANDEL_ESCAPE >> `MANDEL_FRAC;
	localparam int ESC_FRAC = `MANDEL_ESCAPE % (1 << `MANDEL_FRAC);

	logic [1:0] state;
	fixed_t c_real_hold;
	fixed_t c_imag_hold;
	coord_x_t x_hold;
	coord_y_t y_hold;
	logic escaped;
	logic at_limit;
	logic done;

	// strictly greater than 4.0
	assign escaped = (size_squared_out.parts.int_part > ESC_INT) ||
		((size_squared_out.parts.int_part == ESC_INT) &&
		(size_squared_out.parts.frac_part > ESC_FRAC));
	assign at_limit = (pixel == iter_t'(`MANDEL_MAX_ITER));

	// step outputs are only meaningful in the iterate state
	assign done = (state == ST_ITER) && (escaped || at_limit);

	always_ff @(posedge tb_clk, negedge rst_n)
	begin
		if (!rst_n)
		begin
			state <= ST_IDLE;
		end
		else
		begin
			case (state)
				ST_IDLE:
				begin
					if (c_valid)
					begin
						state <= ST_LOAD;
					end
				end
				ST_LOAD:
				begin
					state <= ST_ITER;
				end
				ST_ITER:
				begin
					if (done)
					begin
						state <= ST_IDLE;
					end
				end
				default:
				begin
					state <= ST_IDLE;
				end
			endcase
		end
	end

	// hold c and position for the whole pixel
	always_ff @(posedge tb_clk)
	begin
		if (state == ST_IDLE && c_valid)
		begin
			c_real_hold <= c_real;
			c_imag_hold <= c_imag;
			x_hold <= x;
			y_hold <= y;
		end
	end

	always_comb
	begin
		c_real_in = c_real_hold;
		c_imag_in = c_imag_hold;
		if (state == ST_ITER)
		begin
			// feed the last step back in
			z_real_in = z_real_out;
			z_imag_in = z_imag_out;
			iteration_in = pixel;
		end
		else
		begin
			// z starts at zero
			z_real_in = '0;
			z_imag_in = '0;
			iteration_in = '0;
		end
	end

	assign pixel_valid = done;
	assign pixel_next = done;
	assign pixel_x = x_hold;
	assign pixel_y = y_hold;
	assign pixel_count = pixel;

endmodule

// ==== source/fix_pkg.sv ====
`include "mandel_defs.svh"

package fix_pkg;

	// integral part sits above the binary point
	typedef struct packed
	{
		logic signed [`MANDEL_INT-1:0] int_part;
		logic [`MANDEL_FRAC-1:0] frac_part;
	} fixed_parts_t;

	// same 20 bits seen as one signed number or as two fields
	typedef union packed
	{
		logic signed [`MANDEL_WIDTH-1:0] raw;
		fixed_parts_t parts;
	} fixed_t;

endpackage

// ==== source/frame_pkg.sv ====
`include "mandel_defs.svh"

package frame_pkg;

	// coordinate widths follow the frame size
	typedef logic [$clog2(`MANDEL_FRAME_W)-1:0] coord_x_t;
	typedef logic [$clog2(`MANDEL_FRAME_H)-1:0] coord_y_t;

	// wide enough for counts up to the iteration limit
	typedef logic [7:0] iter_t;

endpackage

// ==== source/mandel_defs.svh ====
`ifndef MANDEL_DEFS_SVH
`define MANDEL_DEFS_SVH

// fixed-point word layout
`define MANDEL_WIDTH 20
`define MANDEL_FRAC 10
`define MANDEL_INT 10

// iterations per pixel before it counts as inside the set
`define MANDEL_MAX_ITER 32

// frame size in pixels
`define MANDEL_FRAME_W 8
`define MANDEL_FRAME_H 6

// |z|^2 threshold, 4.0 in raw form
`define MANDEL_ESCAPE 4096

`endif

// ==== source/mandel_top.sv ====
`timescale 1ns/10ps

module mandel_top import fix_pkg::*, frame_pkg::*;
(
	input logic tb_clk,
	input logic rst_n,
	input logic start,
	input fixed_t origin_real,
	input fixed_t origin_imag,
	input fixed_t step,
	output logic pixel_valid,
	output coord_x_t pixel_x,
	output coord_y_t pixel_y,
	output iter_t pixel_count,
	output logic frame_done,
	output logic busy
);

	// scan to controller
	logic c_valid;
	logic pixel_next;
	coord_x_t x;
	coord_y_t y;
	fixed_t c_real;
	fixed_t c_imag;

	// controller to iteration step and back
	fixed_t z_real_in;
	fixed_t z_imag_in;
	fixed_t c_real_in;
	fixed_t c_imag_in;
	iter_t iteration_in;
	fixed_t z_real_out;
	fixed_t z_imag_out;
	fixed_t size_squared_out;
	iter_t pixel;

	scan_generator scan0
	(
		.tb_clk(tb_clk),
		.rst_n(rst_n),
		.start(start),
		.pixel_next(pixel_next),
		.origin_real(origin_real),
		.origin_imag(origin_imag),
		.step(step),
		.c_valid(c_valid),
		.frame_done(frame_done),
		.busy(busy),
		.x(x),
		.y(y),
		.c_real(c_real),
		.c_imag(c_imag)
	);

	escape_controller ctrl0
	(
		.tb_clk(tb_clk),
		.rst_n(rst_n),
		.c_valid(c_valid),
		.c_real(c_real),
		.c_imag(c_imag),
		.x(x),
		.y(y),
		.z_real_out(z_real_out),
		.z_imag_out(z_imag_out),
		.size_squared_out(size_squared_out),
		.pixel(pixel),
		.z_real_in(z_real_in),
		.z_imag_in(z_imag_in),
		.c_real_in(c_real_in),
		.c_imag_in(c_imag_in),
		.iteration_in(iteration_in),
		.pixel_next(pixel_next),
		.pixel_valid(pixel_valid),
		.pixel_x(pixel_x),
		.pixel_y(pixel_y),
		.pixel_count(pixel_count)
	);

	pixel_calculator calc0
	(
		.tb_clk(tb_clk),
		.rst_n(rst_n),
		.z_real_in(z_real_in),
		.z_imag_in(z_imag_in),
		.c_real_in(c_real_in),
		.c_imag_in(c_imag_in),
		.iteration_in(iteration_in),
		.z_real_out(z_real_out),
		.z_imag_out(z_imag_out),
		.size_squared_out(size_squared_out),
		.pixel(pixel)
	);

endmodule

// ==== source/pixel_calculator.sv ====
`timescale 1ns/10ps
`include "mandel_defs.svh"

module pixel_calculator import fix_pkg::*, frame_pkg::*;
(
	input logic tb_clk,
	input logic rst_n,
	input fixed_t z_real_in,
	input fixed_t z_imag_in,
	input fixed_t c_real_in,
	input fixed_t c_imag_in,
	input iter_t iteration_in,
	output fixed_t z_real_out,
	output fixed_t z_imag_out,
	output fixed_t size_squared_out,
	output iter_t pixel
);

	// full product, rescaled and cut back to one word
	function automatic logic signed [`MANDEL_WIDTH-1:0] fix_mul(
		input logic signed [`MANDEL_WIDTH-1:0] a,
		input logic signed [`MANDEL_WIDTH-1:0] b
	);
		logic signed [2*`MANDEL_WIDTH-1:0] prod;
		prod = a * b;
		return prod[`MANDEL_WIDTH+`MANDEL_FRAC-1:`MANDEL_FRAC];
	endfunction

	logic signed [`MANDEL_WIDTH-1:0] zr_sq;
	logic signed [`MANDEL_WIDTH-1:0] zi_sq;
	logic signed [`MANDEL_WIDTH-1:0] zr_zi;
	logic signed [`MANDEL_WIDTH-1:0] next_real;
	logic signed [`MANDEL_WIDTH-1:0] next_imag;
	logic signed [`MANDEL_WIDTH-1:0] next_size;

	always_comb
	begin
		zr_sq = fix_mul(z_real_in.raw, z_real_in.raw);
		zi_sq = fix_mul(z_imag_in.raw, z_imag_in.raw);
		zr_zi = fix_mul(z_real_in.raw, z_imag_in.raw);

		// z^2 + c
		next_real = zr_sq - zi_sq + c_real_in.raw;
		// doubling after the shift, as the model does
		next_imag = (zr_zi <<< 1) + c_imag_in.raw;

		// magnitude of the new z, for the escape test downstream
		next_size = fix_mul(next_real, next_real) + fix_mul(next_imag, next_imag);
	end

	always_ff @(posedge tb_clk)
	begin
		z_real_out.raw <= next_real;
		z_imag_out.raw <= next_imag;
		size_squared_out.raw <= next_size;
	end

	// count travels with the data it belongs to
	always_ff @(posedge tb_clk, negedge rst_n)
	begin
		if (!rst_n)
		begin
			pixel <= '0;
		end
		else
		begin
			pixel <= iteration_in + iter_t'(1);
		end
	end

endmodule

// ==== source/scan_generator.sv ====
`timescale 1ns/10ps
`include "mandel_defs.svh"

module scan_generator import fix_pkg::*, frame_pkg::*;
(
	input logic tb_clk,
	input logic rst_n,
	input logic start,
	input logic pixel_next,
	input fixed_t origin_real,
	input fixed_t origin_imag,
	input fixed_t step,
	output logic c_valid,
	output logic frame_done,
	output logic busy,
	output coord_x_t x,
	output coord_y_t y,
	output fixed_t c_real,
	output fixed_t c_imag
);

	logic load_frame;
	logic advance;
	logic last_col;
	logic last_row;

	// start is ignored while a frame is running
	assign load_frame = start && !busy;
	assign advance = busy && pixel_next;
	assign last_col = (x == coord_x_t'(`MANDEL_FRAME_W - 1));
	assign last_row = (y == coord_y_t'(`MANDEL_FRAME_H - 1));

	always_ff @(posedge tb_clk, negedge rst_n)
	begin
		if (!rst_n)
		begin
			c_valid <= 1'b0;
			frame_done <= 1'b0;
			busy <= 1'b0;
			x <= '0;
			y <= '0;
		end
		else
		begin
			c_valid <= 1'b0;
			frame_done <= 1'b0;
			if (load_frame)
			begin
				busy <= 1'b1;
				c_valid <= 1'b1;
				x <= '0;
				y <= '0;
			end
			else if (advance)
			begin
				if (last_col && last_row)
				begin
					// busy drops together with the done pulse
					busy <= 1'b0;
					frame_done <= 1'b1;
				end
				else if (last_col)
				begin
					x <= '0;
					y <= y + coord_y_t'(1);
					c_valid <= 1'b1;
				end
				else
				begin
					x <= x + coord_x_t'(1);
					c_valid <= 1'b1;
				end
			end
		end
	end

	// c stepped by addition only
	always_ff @(posedge tb_clk)
	begin
		if (load_frame)
		begin
			c_real <= origin_real;
			c_imag <= origin_imag;
		end
		else if (advance && !last_col)
		begin
			c_real.raw <= c_real.raw + step.raw;
		end
		else if (advance && !last_row)
		begin
			// new row, back to the left edge and one step down
			c_real <= origin_real;
			c_imag.raw <= c_imag.raw + step.raw;
		end
	end

endmodule

// ==== verification/mandel_assert.sv ====
`timescale 1ns/10ps
`include "mandel_defs.svh"

module mandel_assert import frame_pkg::*;
(
	input logic tb_clk,
	input logic rst_n,
	input logic start,
	input logic busy,
	input logic pixel_valid,
	input logic frame_done,
	input coord_x_t pixel_x,
	input coord_y_t pixel_y
);

	localparam int PIXELS = `MANDEL_FRAME_W * `MANDEL_FRAME_H;

	// failed properties, read back by the testbench at the end
	int fail_count = 0;
	// raster index of the pixel expected next
	int next_index;

	always_ff @(posedge tb_clk, negedge rst_n)
	begin
		if (!rst_n)
		begin
			next_index <= 0;
		end
		else if (start && !busy)
		begin
			next_index <= 0;
		end
		else if (pixel_valid)
		begin
			next_index <= next_index + 1;
		end
	end

	// nothing happens between frames unless start comes
	a_quiet_until_start: assert property (@(posedge tb_clk) disable iff (!rst_n)
		(!busy && !start) |=> (!busy && !pixel_valid))
	else
	begin
		fail_count++;
		$error("busy or pixel_valid rose without a start pulse");
	end

	// results follow the raster, a second start does not restart it
	a_raster_order: assert property (@(posedge tb_clk) disable iff (!rst_n)
		pixel_valid |-> ((int'(pixel_x) == next_index % `MANDEL_FRAME_W) &&
		(int'(pixel_y) == next_index / `MANDEL_FRAME_W)))
	else
	begin
		fail_count++;
		$error("pixel out of raster order");
	end

	// done comes right after the last of all pixels
	a_frame_done: assert property (@(posedge tb_clk) disable iff (!rst_n)
		frame_done |-> (!busy && $past(pixel_valid) && next_index == PIXELS))
	else
	begin
		fail_count++;
		$error("frame_done at the wrong time or after the wrong pixel count");
	end

	a_busy_falls: assert property (@(posedge tb_clk) disable iff (!rst_n)
		$fell(busy) |-> frame_done)
	else
	begin
		fail_count++;
		$error("busy fell without frame_done");
	end

endmodule

// ==== verification/tb_mandel_top.sv ====
`timescale 1ns/10ps
`include "mandel_defs.svh"

module tb_mandel_top import fix_pkg::*, frame_pkg::*;
();

	localparam int PIXELS = `MANDEL_FRAME_W * `MANDEL_FRAME_H;
	localparam int WAIT_LIMIT = `MANDEL_MAX_ITER + 4;

	logic tb_clk;
	logic rst_n;
	logic start;
	fixed_t origin_real;
	fixed_t origin_imag;
	fixed_t step;
	logic pixel_valid;
	coord_x_t pixel_x;
	coord_y_t pixel_y;
	iter_t pixel_count;
	logic frame_done;
	logic busy;

	int value_errors;
	int timeout_errors;
	int cycle_count;
	bit timed_out;

	mandel_top dut0
	(
		.tb_clk(tb_clk),
		.rst_n(rst_n),
		.start(start),
		.origin_real(origin_real),
		.origin_imag(origin_imag),
		.step(step),
		.pixel_valid(pixel_valid),
		.pixel_x(pixel_x),
		.pixel_y(pixel_y),
		.pixel_count(pixel_count),
		.frame_done(frame_done),
		.busy(busy)
	);

	bind mandel_top mandel_assert assert0
	(
		.tb_clk(tb_clk),
		.rst_n(rst_n),
		.start(start),
		.busy(busy),
		.pixel_valid(pixel_valid),
		.frame_done(frame_done),
		.pixel_x(pixel_x),
		.pixel_y(pixel_y)
	);

	initial
	begin
		tb_clk = 1'b0;
		forever
		begin
			#4 tb_clk = ~tb_clk;
		end
	end

	// signed product rescaled by the fraction bits, kept to one word
	function automatic logic signed [`MANDEL_WIDTH-1:0] fixed_product(
		input logic signed [`MANDEL_WIDTH-1:0] a,
		input logic signed [`MANDEL_WIDTH-1:0] b
	);
		logic signed [2*`MANDEL_WIDTH-1:0] wide_a;
		logic signed [2*`MANDEL_WIDTH-1:0] wide_b;
		logic signed [2*`MANDEL_WIDTH-1:0] full;
		wide_a = a;
		wide_b = b;
		full = (wide_a * wide_b) >>> `MANDEL_FRAC;
		return full[`MANDEL_WIDTH-1:0];
	endfunction

	// iterations until |z|^2 > 4.0 or the limit
	function automatic int predict_count(
		input logic signed [`MANDEL_WIDTH-1:0] cr,
		input logic signed [`MANDEL_WIDTH-1:0] ci
	);
		logic signed [`MANDEL_WIDTH-1:0] zr;
		logic signed [`MANDEL_WIDTH-1:0] zi;
		logic signed [`MANDEL_WIDTH-1:0] nr;
		logic signed [`MANDEL_WIDTH-1:0] ni;
		logic signed [`MANDEL_WIDTH-1:0] twice;
		logic signed [`MANDEL_WIDTH-1:0] size;
		int n;
		zr = '0;
		zi = '0;
		for (n = 1; n < `MANDEL_MAX_ITER; n++)
		begin
			nr = fixed_product(zr, zr) - fixed_product(zi, zi) + cr;
			twice = fixed_product(zr, zi) + fixed_product(zr, zi);
			ni = twice + ci;
			size = fixed_product(nr, nr) + fixed_product(ni, ni);
			if (size > `MANDEL_ESCAPE)
			begin
				return n;
			end
			zr = nr;
			zi = ni;
		end
		return `MANDEL_MAX_ITER;
	endfunction

	task automatic next_cycle();
		@(posedge tb_clk);
		#1;
		cycle_count++;
	endtask

	task automatic check_value(input string name, input int expected, input int actual);
		assert (actual == expected)
		else
		begin
			value_errors++;
			$display("error at %0t: %s expected %0d, got %0d", $time, name, expected, actual);
		end
	endtask

	task automatic check_idle(input int cycles);
		int i;
		for (i = 0; i < cycles; i++)
		begin
			check_value("busy", 0, int'(busy));
			check_value("pixel_valid", 0, int'(pixel_valid));
			check_value("frame_done", 0, int'(frame_done));
			next_cycle();
		end
	endtask

	task automatic run_frame(input int org_r, input int org_i, input int stp, input bit extra_start);
		int index;
		int waited;
		int expected;
		int last_cycle;
		int cr;
		int ci;
		origin_real.raw = `MANDEL_WIDTH'(org_r);
		origin_imag.raw = `MANDEL_WIDTH'(org_i);
		step.raw = `MANDEL_WIDTH'(stp);
		start = 1'b1;
		last_cycle = cycle_count;
		next_cycle();
		start = 1'b0;
		check_value("busy", 1, int'(busy));
		for (index = 0; index < PIXELS; index++)
		begin
			// c of this pixel, stepped from the origin
			cr = org_r + (index % `MANDEL_FRAME_W) * stp;
			ci = org_i + (index / `MANDEL_FRAME_W) * stp;
			expected = predict_count(`MANDEL_WIDTH'(cr), `MANDEL_WIDTH'(ci));
			waited = 0;
			while (!pixel_valid && waited < WAIT_LIMIT)
			begin
				next_cycle();
				waited++;
			end
			if (!pixel_valid)
			begin
				timeout_errors++;
				timed_out = 1'b1;
				$display("timeout: pixel %0d did not arrive within %0d cycles", index, waited);
				return;
			end
			check_value("pixel_x", index % `MANDEL_FRAME_W, int'(pixel_x));
			check_value("pixel_y", index / `MANDEL_FRAME_W, int'(pixel_y));
			check_value("pixel_count", expected, int'(pixel_count));
			check_value("pixel spacing", expected + 2, cycle_count - last_cycle);
			last_cycle = cycle_count;
			// start in mid frame, must be ignored
			start = extra_start && (index == 20);
			next_cycle();
			start = 1'b0;
		end
		check_value("frame_done", 1, int'(frame_done));
		check_value("busy", 0, int'(busy));
		next_cycle();
		check_value("frame_done", 0, int'(frame_done));
	endtask

	initial
	begin
		int org_r;
		int org_i;
		int stp;
		value_errors = 0;
		timeout_errors = 0;
		cycle_count = 0;
		timed_out = 1'b0;
		rst_n = 1'b0;
		start = 1'b0;
		origin_real = '0;
		origin_imag = '0;
		step = '0;
		void'($urandom(43369));
		repeat (5) @(posedge tb_clk);
		#1;
		rst_n = 1'b1;
		check_idle(10);
		// -2.0 - 1.0i with a step of 0.375
		run_frame(-2048, -1024, 384, 1'b1);
		if (!timed_out)
		begin
			check_idle(40);
			org_r = int'($urandom_range(1792, 0)) - 2304;
			org_i = int'($urandom_range(1536, 0)) - 1536;
			stp = int'($urandom_range(384, 64));
			run_frame(org_r, org_i, stp, 1'b0);
		end
		if (!timed_out)
		begin
			check_idle(5);
		end
		$display("errors: value %0d, timeout %0d, assertion %0d",
			value_errors, timeout_errors, dut0.assert0.fail_count);
		if (value_errors == 0 && timeout_errors == 0 && dut0.assert0.fail_count == 0)
		begin
			$display("all tests passed");
		end
		else
		begin
			$display("tests failed");
		end
		$finish;
	end

endmodule
